//--- common/fp24_pkg.sv
// 24-bit float format: field widths, exponent bias, zero word, leading-zero count
package fp24_pkg;

  // Word layout is {sign, exponent, mantissa}
  localparam int FP_W = 24;
  localparam int EXP_W = 7;
  localparam int MANT_W = 16;

  localparam logic [EXP_W-1:0] EXP_BIAS = 7'd63;

  // Zero is the only word with exponent and mantissa both clear
  localparam logic [FP_W-1:0] FP_ZERO = '0;

  // Leading zeros of a 17-bit fraction, 17 when no bit is set
  function automatic logic [4:0] clz17(input logic [16:0] x);
    logic [4:0] cnt;
    cnt = 5'd17;
    // Scan upward so the highest set bit wins
    for (int i = 0; i <= 16; i++) begin
      if (x[i]) begin
        cnt = 5'(16 - i);
      end
    end
    return cnt;
  endfunction

endpackage

//--- common/fpu_op_pkg.sv
// FPU operation codes and pipeline latency
package fpu_op_pkg;

  typedef enum logic [1:0] {
    OP_ADD = 2'b00,
    OP_SUB = 2'b01,
    OP_MUL = 2'b10
  } fpu_op_e;

  // Edges from the sampling of an operation to out_valid
  localparam int PIPE_LAT = 3;

endpackage

//--- fp_add/fp24_add.sv
// Two-stage 24-bit float add/subtract datapath with truncation
`timescale 1ns/100ps

module fp24_add (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic [fp24_pkg::FP_W-1:0]  a,
  input  logic [fp24_pkg::FP_W-1:0]  b,
  input  logic                       is_sub,
  output logic [fp24_pkg::FP_W-1:0]  sum
);

  // Operand b with its sign flipped for subtraction
  logic [fp24_pkg::FP_W-1:0]   b_eff;
  logic                        swap;
  logic [fp24_pkg::FP_W-1:0]   big;
  logic [fp24_pkg::FP_W-1:0]   little;
  logic [fp24_pkg::EXP_W-1:0]  exp_diff;
  logic [fp24_pkg::MANT_W:0]   frac_big;
  logic [fp24_pkg::MANT_W:0]   frac_small;
  logic                        a_is_zero;
  logic                        b_is_zero;

  // Stage 1 registers
  logic                        s1_sign;
  logic                        s1_sub;
  logic [fp24_pkg::EXP_W-1:0]  s1_exp;
  logic [fp24_pkg::MANT_W:0]   s1_frac_big;
  logic [fp24_pkg::MANT_W:0]   s1_frac_small;
  logic                        s1_bypass;
  logic [fp24_pkg::FP_W-1:0]   s1_bypass_val;

  // Stage 2 arithmetic
  logic [fp24_pkg::MANT_W+1:0] frac_sum;
  logic [4:0]                  lz;
  logic [fp24_pkg::EXP_W-1:0]  lz_ext;
  logic [fp24_pkg::MANT_W:0]   frac_norm;
  logic [fp24_pkg::EXP_W-1:0]  exp_norm;
  logic [fp24_pkg::FP_W-1:0]   sum_next;

  assign b_eff = {b[fp24_pkg::FP_W-1] ^ is_sub, b[fp24_pkg::FP_W-2:0]};

  // Magnitude compare on exponent and mantissa together
  assign swap   = b[fp24_pkg::FP_W-2:0] > a[fp24_pkg::FP_W-2:0];
  assign big    = swap ? b_eff : a;
  assign little = swap ? a : b_eff;

  assign a_is_zero = (a[fp24_pkg::FP_W-2:0] == '0);
  assign b_is_zero = (b[fp24_pkg::FP_W-2:0] == '0);

  assign exp_diff   = big[fp24_pkg::FP_W-2:fp24_pkg::MANT_W]
                    - little[fp24_pkg::FP_W-2:fp24_pkg::MANT_W];
  assign frac_big   = {1'b1, big[fp24_pkg::MANT_W-1:0]};
  // Align the smaller fraction to the larger exponent
  assign frac_small = {1'b1, little[fp24_pkg::MANT_W-1:0]} >> exp_diff;

  // Stage 1 bypass flag
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      s1_bypass <= 1'b0;
    end else begin
      s1_bypass <= a_is_zero | b_is_zero;
    end
  end

  // Stage 1 payload
  always_ff @(posedge clk) begin
    s1_sign       <= big[fp24_pkg::FP_W-1];
    s1_sub        <= big[fp24_pkg::FP_W-1] ^ little[fp24_pkg::FP_W-1];
    s1_exp        <= big[fp24_pkg::FP_W-2:fp24_pkg::MANT_W];
    s1_frac_big   <= frac_big;
    s1_frac_small <= frac_small;
    // Zero operand passes the other one through
    s1_bypass_val <= b_is_zero ? a : b_eff;
  end

  // Larger magnitude comes first so the difference never goes negative
  assign frac_sum = s1_sub ? {1'b0, s1_frac_big} - {1'b0, s1_frac_small}
                           : {1'b0, s1_frac_big} + {1'b0, s1_frac_small};

  assign lz     = fp24_pkg::clz17(frac_sum[fp24_pkg::MANT_W:0]);
  assign lz_ext = {{(fp24_pkg::EXP_W-5){1'b0}}, lz};

  always_comb begin
    if (frac_sum[fp24_pkg::MANT_W+1]) begin
      // Carry out shifts right and bumps the exponent
      frac_norm = frac_sum[fp24_pkg::MANT_W+1:1];
      exp_norm  = s1_exp + 1'b1;
    end else begin
      frac_norm = frac_sum[fp24_pkg::MANT_W:0] << lz;
      exp_norm  = s1_exp - lz_ext;
    end

    if (s1_bypass) begin
      sum_next = s1_bypass_val;
    end else if (frac_sum == '0) begin
      sum_next = fp24_pkg::FP_ZERO;
    end else begin
      // Hidden bit dropped and lower bits truncated
      sum_next = {s1_sign, exp_norm, frac_norm[fp24_pkg::MANT_W-1:0]};
    end
  end

  always_ff @(posedge clk) begin
    sum <= sum_next;
  end

endmodule

//--- fp_mul/fp24_mul.sv
// Two-stage 24-bit float multiply datapath with truncation
`timescale 1ns/100ps

module fp24_mul (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic [fp24_pkg::FP_W-1:0] a,
  input  logic [fp24_pkg::FP_W-1:0] b,
  output logic [fp24_pkg::FP_W-1:0] prod
);

  logic [fp24_pkg::MANT_W:0]       frac_a;
  logic [fp24_pkg::MANT_W:0]       frac_b;
  logic                            any_zero;

  // Stage 1 registers
  logic                            s1_sign;
  logic [fp24_pkg::EXP_W-1:0]      s1_exp;
  logic [2*fp24_pkg::MANT_W+1:0]   s1_prod;
  logic                            s1_zero;

  // Stage 2 normalization
  logic [fp24_pkg::MANT_W-1:0]     mant_norm;
  logic [fp24_pkg::EXP_W-1:0]      exp_norm;
  logic [fp24_pkg::FP_W-1:0]       prod_next;

  assign frac_a   = {1'b1, a[fp24_pkg::MANT_W-1:0]};
  assign frac_b   = {1'b1, b[fp24_pkg::MANT_W-1:0]};
  assign any_zero = (a[fp24_pkg::FP_W-2:0] == '0) || (b[fp24_pkg::FP_W-2:0] == '0);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      s1_zero <= 1'b0;
    end else begin
      s1_zero <= any_zero;
    end
  end

  always_ff @(posedge clk) begin
    s1_sign <= a[fp24_pkg::FP_W-1] ^ b[fp24_pkg::FP_W-1];
    // Exponent sum wraps, out-of-range cases are not detected
    s1_exp  <= a[fp24_pkg::FP_W-2:fp24_pkg::MANT_W]
             + b[fp24_pkg::FP_W-2:fp24_pkg::MANT_W]
             - fp24_pkg::EXP_BIAS;
    s1_prod <= frac_a * frac_b;
  end

  // Product of two [1,2) fractions lies in [1,4)
  always_comb begin
    if (s1_prod[2*fp24_pkg::MANT_W+1]) begin
      mant_norm = s1_prod[2*fp24_pkg::MANT_W:fp24_pkg::MANT_W+1];
      exp_norm  = s1_exp + 1'b1;
    end else begin
      mant_norm = s1_prod[2*fp24_pkg::MANT_W-1:fp24_pkg::MANT_W];
      exp_norm  = s1_exp;
    end

    if (s1_zero) begin
      prod_next = fp24_pkg::FP_ZERO;
    end else begin
      prod_next = {s1_sign, exp_norm, mant_norm};
    end
  end

  always_ff @(posedge clk) begin
    prod <= prod_next;
  end

endmodule

//--- verilog/fpu_retire.sv
// Valid and opcode tracking, result select and zero flag register
`timescale 1ns/100ps

module fpu_retire (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic                      in_valid,
  input  fpu_op_pkg::fpu_op_e       op,
  input  logic [fp24_pkg::FP_W-1:0] add_res,
  input  logic [fp24_pkg::FP_W-1:0] mul_res,
  output logic                      out_valid,
  output logic [fp24_pkg::FP_W-1:0] result,
  output logic                      zero
);

  // One entry per datapath stage
  logic [fpu_op_pkg::PIPE_LAT-2:0] vld_sr;
  fpu_op_pkg::fpu_op_e             op_sr [fpu_op_pkg::PIPE_LAT-1];

  logic [fp24_pkg::FP_W-1:0]       sel_res;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      vld_sr <= '0;
      for (int i = 0; i < fpu_op_pkg::PIPE_LAT - 1; i++) begin
        op_sr[i] <= fpu_op_pkg::OP_ADD;
      end
    end else begin
      vld_sr <= {vld_sr[fpu_op_pkg::PIPE_LAT-3:0], in_valid};
      op_sr[0] <= op;
      for (int i = 1; i < fpu_op_pkg::PIPE_LAT - 1; i++) begin
        op_sr[i] <= op_sr[i-1];
      end
    end
  end

  // Last entry lines up with the stage-2 results
  assign sel_res = (op_sr[fpu_op_pkg::PIPE_LAT-2] == fpu_op_pkg::OP_MUL) ? mul_res : add_res;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
      result    <= fp24_pkg::FP_ZERO;
      zero      <= 1'b0;
    end else begin
      out_valid <= vld_sr[fpu_op_pkg::PIPE_LAT-2];
      // Hold the last result between operations
      if (vld_sr[fpu_op_pkg::PIPE_LAT-2]) begin
        result <= sel_res;
        zero   <= (sel_res[fp24_pkg::FP_W-2:0] == '0);
      end
    end
  end

endmodule

//--- verilog/fpu24_top.sv
// 24-bit FPU top level with adder, multiplier and retire stage
`timescale 1ns/100ps

module fpu24_top (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic                      in_valid,
  input  fpu_op_pkg::fpu_op_e       op,
  input  logic [fp24_pkg::FP_W-1:0] a,
  input  logic [fp24_pkg::FP_W-1:0] b,
  output logic                      out_valid,
  output logic [fp24_pkg::FP_W-1:0] result,
  output logic                      zero
);

  logic                      is_sub;
  logic [fp24_pkg::FP_W-1:0] add_res;
  logic [fp24_pkg::FP_W-1:0] mul_res;

  assign is_sub = (op == fpu_op_pkg::OP_SUB);

  // Both datapaths run every cycle, retire picks one
  fp24_add add_i (
    .clk    (clk),
    .arst_n (arst_n),
    .a      (a),
    .b      (b),
    .is_sub (is_sub),
    .sum    (add_res)
  );

  fp24_mul mul_i (
    .clk    (clk),
    .arst_n (arst_n),
    .a      (a),
    .b      (b),
    .prod   (mul_res)
  );

  fpu_retire retire_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .op        (op),
    .add_res   (add_res),
    .mul_res   (mul_res),
    .out_valid (out_valid),
    .result    (result),
    .zero      (zero)
  );

endmodule

//--- verif/fpu24_checker.sv
// Result checker for the 24-bit FPU: expectation queue, compare and per-test report
`timescale 1ns/100ps

module fpu24_checker (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic                      in_valid,
  input  logic                      out_valid,
  input  logic [fp24_pkg::FP_W-1:0] result,
  input  logic                      zero
);

  string                     name_q [$];
  logic [fp24_pkg::FP_W-1:0] exp_q [$];
  int                        issue_q [$];

  int n_pass = 0;
  int n_fail = 0;
  int n_err  = 0;
  int cycle  = 0;

  string                     cur_name;
  logic [fp24_pkg::FP_W-1:0] cur_exp;
  int                        cur_issue;
  logic                      exp_zero;
  logic                      ok;

  task automatic expect_result(input string name, input logic [fp24_pkg::FP_W-1:0] value);
    name_q.push_back(name);
    exp_q.push_back(value);
  endtask

  task automatic report_failure(input string what);
    $display("ERROR: %s", what);
    n_err++;
  endtask

  function automatic int pending();
    return exp_q.size();
  endfunction

  // Outputs right after reset release
  task automatic check_reset_state();
    if (out_valid !== 1'b0 || result !== fp24_pkg::FP_ZERO || zero !== 1'b0) begin
      $display("MISMATCH reset_state: expected %0b_%06h_%0b, actual %0b_%06h_%0b",
               1'b0, fp24_pkg::FP_ZERO, 1'b0, out_valid, result, zero);
      n_fail++;
      n_err++;
    end else begin
      $display("PASS reset_state");
      n_pass++;
    end
  endtask

  // Sampled on the rising edge, before the DUT registers update
  always @(posedge clk) begin
    cycle++;
    if (!arst_n) begin
      if (out_valid === 1'b1) begin
        report_failure("out_valid is high while reset is asserted");
      end
    end else begin
      if (out_valid === 1'b1) begin
        if (issue_q.size() == 0 || exp_q.size() == 0) begin
          report_failure("out_valid went high with no operation in flight");
        end else begin
          cur_name  = name_q.pop_front();
          cur_exp   = exp_q.pop_front();
          cur_issue = issue_q.pop_front();
          exp_zero  = (cur_exp[fp24_pkg::FP_W-2:0] == '0);
          ok        = 1'b1;
          if (result !== cur_exp) begin
            $display("MISMATCH %s: expected %06h, actual %06h", cur_name, cur_exp, result);
            ok = 1'b0;
          end
          if (zero !== exp_zero) begin
            $display("MISMATCH %s zero flag: expected %0b, actual %0b",
                     cur_name, exp_zero, zero);
            ok = 1'b0;
          end
          if (cycle - cur_issue != fpu_op_pkg::PIPE_LAT) begin
            $display("ERROR: %s came back after %0d cycles instead of %0d",
                     cur_name, cycle - cur_issue, fpu_op_pkg::PIPE_LAT);
            ok = 1'b0;
          end
          if (ok) begin
            $display("PASS %s", cur_name);
            n_pass++;
          end else begin
            n_fail++;
            n_err++;
          end
        end
      end else if (issue_q.size() > 0 && cycle - issue_q[0] > fpu_op_pkg::PIPE_LAT) begin
        // Oldest operation is overdue
        cur_issue = issue_q.pop_front();
        cur_exp   = exp_q.pop_front();
        cur_name  = name_q.pop_front();
        $display("ERROR: %s never produced a result", cur_name);
        n_fail++;
        n_err++;
      end
      if (in_valid === 1'b1) begin
        issue_q.push_back(cycle);
      end
    end
  end

endmodule

//--- verif/fpu24_tb.sv
// Testbench top for the 24-bit FPU: clock, reset, vector file reader and issue loop
`timescale 1ns/100ps

module fpu24_tb;

  localparam int DRAIN_LIMIT = 20;

  logic                      clk;
  logic                      arst_n;
  logic                      in_valid;
  fpu_op_pkg::fpu_op_e       op;
  logic [fp24_pkg::FP_W-1:0] a;
  logic [fp24_pkg::FP_W-1:0] b;
  logic                      out_valid;
  logic [fp24_pkg::FP_W-1:0] result;
  logic                      zero;

  logic [31:0]               lfsr_state;

  string                     vec_names [$];
  logic [1:0]                vec_ops [$];
  logic [fp24_pkg::FP_W-1:0] vec_a [$];
  logic [fp24_pkg::FP_W-1:0] vec_b [$];
  logic [fp24_pkg::FP_W-1:0] vec_exp [$];

  fpu24_top dut_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .op        (op),
    .a         (a),
    .b         (b),
    .out_valid (out_valid),
    .result    (result),
    .zero      (zero)
  );

  fpu24_checker checker_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .out_valid (out_valid),
    .result    (result),
    .zero      (zero)
  );

  initial begin
    clk = 1'b0;
  end

  always #5 clk = ~clk;

  // Galois form, one step per bit
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  task automatic draw_bits(input int n, output int value);
    value = 0;
    for (int i = 0; i < n; i++) begin
      value = (value << 1) | int'(lfsr_state[0]);
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  task automatic load_vectors();
    int          fd;
    int          n;
    string       line;
    string       name;
    logic [31:0] op_raw;
    logic [31:0] va;
    logic [31:0] vb;
    logic [31:0] ve;
    fd = $fopen("verif/fpu24_stim.txt", "r");
    if (fd == 0) begin
      checker_i.report_failure("could not open verif/fpu24_stim.txt");
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      // Skip blank and comment lines
      if (line.len() < 2 || line[0] == 8'h23) begin
        continue;
      end
      n = $sscanf(line, "%s %h %h %h %h", name, op_raw, va, vb, ve);
      if (n == 5) begin
        vec_names.push_back(name);
        vec_ops.push_back(op_raw[1:0]);
        vec_a.push_back(va[fp24_pkg::FP_W-1:0]);
        vec_b.push_back(vb[fp24_pkg::FP_W-1:0]);
        vec_exp.push_back(ve[fp24_pkg::FP_W-1:0]);
      end else if (n > 0) begin
        checker_i.report_failure({"malformed line in stimulus file: ", line});
      end
    end
    $fclose(fd);
    if (vec_names.size() == 0) begin
      checker_i.report_failure("no vectors were read from the stimulus file");
    end
  endtask

  // Called on a falling edge, returns on the next one
  task automatic issue_vector(input int idx, input string tag);
    in_valid = 1'b1;
    op       = fpu_op_pkg::fpu_op_e'(vec_ops[idx]);
    a        = vec_a[idx];
    b        = vec_b[idx];
    checker_i.expect_result({vec_names[idx], tag}, vec_exp[idx]);
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  initial begin
    int gap;
    int wait_cnt;
    arst_n     = 1'b0;
    in_valid   = 1'b0;
    op         = fpu_op_pkg::OP_ADD;
    a          = '0;
    b          = '0;
    lfsr_state = 32'h0223_a89e;
    load_vectors();

    repeat (3) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);
    checker_i.check_reset_state();

    // First pass with random idle gaps of 0 to 3 cycles
    for (int i = 0; i < vec_names.size(); i++) begin
      draw_bits(2, gap);
      repeat (gap) @(negedge clk);
      issue_vector(i, "");
    end

    // Second pass back to back
    for (int i = 0; i < vec_names.size(); i++) begin
      issue_vector(i, "_b2b");
    end

    wait_cnt = 0;
    while (checker_i.pending() > 0 && wait_cnt < DRAIN_LIMIT) begin
      @(negedge clk);
      wait_cnt++;
    end
    if (checker_i.pending() > 0) begin
      checker_i.report_failure("timed out waiting for the last results");
    end
    // Catch any stray out_valid after the last result
    repeat (fpu_op_pkg::PIPE_LAT + 1) @(negedge clk);

    $display("Summary: %0d tests passed, %0d tests failed, %0d errors in total",
             checker_i.n_pass, checker_i.n_fail, checker_i.n_err);
    if (checker_i.n_err == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- verif/fpu24_stim.txt
# columns: name, op (0 add, 1 sub, 2 mul), a, b, expected result
# a, b and expected are 24-bit words {sign, exp bias 63, 16-bit mantissa} in hex
add_one_one      0 3f0000 3f0000 400000
add_carry_mant   0 3f8000 3f4000 406000
add_align        0 400000 3e8000 406000
add_truncate     0 3f0000 3c0001 3f2000
add_mixed_sign   0 400000 be0000 3f8000
sub_renorm       1 3f8000 3f4000 3d0000
sub_swap_neg     1 3f0000 3fc000 be8000
sub_cancel       1 3f8000 3f8000 000000
add_zero_a       0 000000 3f8000 3f8000
sub_zero_a       1 000000 3f8000 bf8000
sub_zero_b       1 3f8000 000000 3f8000
sub_zero_b_neg   1 c00000 000000 c00000
mul_norm_shift   2 3f8000 3f8000 402000
mul_no_shift     2 3f4000 3f8000 3fe000
mul_sign_neg     2 c00000 3f8000 c08000
mul_sign_pos     2 be0000 be8000 3d8000
mul_zero         2 408000 000000 000000
mul_truncate     2 3f0001 3f0001 3f0002

//--- vlog.f
common/fp24_pkg.sv
common/fpu_op_pkg.sv
fp_add/fp24_add.sv
fp_mul/fp24_mul.sv
verilog/fpu_retire.sv
verilog/fpu24_top.sv
verif/fpu24_checker.sv
verif/fpu24_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the FPU testbench with Verilator, then check the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -Wno-fatal -f vlog.f --top-module fpu24_tb -o fpu24_sim \
  > sim.log 2>&1 \
  && ./obj_dir/fpu24_sim >> sim.log 2>&1

grep -qx "No errors" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed, see sim.log"; exit 1; }
